/* sources.f */
+incdir+design
design/esp_link_pkg.sv
design/spi_target.sv
design/cmd_decode.sv
design/cmd_execute.sv
design/reply_select.sv
design/esp_link_top.sv
tb/esp_link_props.sv
tb/tb_esp_link.sv

/* Makefile */
TOP = tb_esp_link

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/tb_esp_link.sv */
`timescale 1ns/1ps
`include "esp_link_settings.svh"

module tb_esp_link;

  import esp_link_pkg::*;

  localparam int half_sck = 10;  // clk cycles per sck half period
  // about 24 bytes of 160 cycles plus frame gaps, near 4200 cycles, with margin
  localparam int cycle_limit = 20000;

  logic        clk = 1'b0;
  logic        rst;
  logic        sck;
  logic        mosi;
  logic        cs_n;
  logic [3:0]  conf;
  logic        miso;
  logic        led_red;
  logic        led_green;
  logic        led_blue;
  byte_t       esp_status;
  logic        full_addr;
  logic [23:0] screen_color;
  logic [31:0] lfsr = 32'h02f331d6;
  int          cycles = 0;

  esp_link_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .sck          (sck),
    .mosi         (mosi),
    .cs_n         (cs_n),
    .conf         (conf),
    .miso         (miso),
    .led_red      (led_red),
    .led_green    (led_green),
    .led_blue     (led_blue),
    .esp_status   (esp_status),
    .full_addr    (full_addr),
    .screen_color (screen_color)
  );

  bind esp_link_top esp_link_props props0 (
    .clk          (clk),
    .rst          (rst),
    .cs_n         (cs_n),
    .miso         (miso),
    .led_red      (led_red),
    .led_green    (led_green),
    .led_blue     (led_blue),
    .esp_status   (esp_status),
    .full_addr    (full_addr),
    .screen_color (screen_color)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "check failed");
  endtask

  always @(posedge clk) begin
    if (dut0.props0.err_cnt != 0) begin
      $display("A property in esp_link_props failed");
      abort_run();
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
      abort_run();
    end
  endtask

  // n rising edges, then a little drive delay
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_byte(output byte_t b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  // mode 0, msb first
  task automatic shift_bits(input byte_t tx, input int nbits, output byte_t rx);
    rx = '0;
    for (int i = 7; i > 7 - nbits; i--) begin
      mosi = tx[i];
      tick(half_sck);
      rx = {rx[6:0], miso};  // taken as sck rises
      sck = 1'b1;
      tick(half_sck);
      sck = 1'b0;
    end
  endtask

  task automatic start_frame();
    cs_n = 1'b0;
    tick(half_sck);
  endtask

  task automatic end_frame();
    tick(half_sck);
    cs_n = 1'b1;
    mosi = 1'b0;
    tick(half_sck);
  endtask

  // whole bytes in one cs_n frame, returns what came back in the last one
  task automatic send_frame(input byte_t bytes [4], input int n, output byte_t last_rx);
    start_frame();
    for (int i = 0; i < n; i++) begin
      shift_bits(bytes[i], 8, last_rx);
    end
    end_frame();
  endtask

  initial begin
    byte_t p0;
    byte_t p1;
    byte_t p2;
    byte_t rx;
    rst = 1'b1;
    sck = 1'b0;
    mosi = 1'b0;
    cs_n = 1'b1;
    conf = 4'h0;
    tick(16);
    rst = 1'b0;
    tick(2);

    check_value("led_red", 32'(led_red), 32'd0);
    check_value("led_green", 32'(led_green), 32'd0);
    check_value("led_blue", 32'(led_blue), 32'd0);
    check_value("esp_status", 32'(esp_status), 32'd0);
    check_value("full_addr", 32'(full_addr), 32'd0);
    check_value("screen_color", 32'(screen_color), 32'(`ESP_SCREEN_COLOR_RST));

    random_byte(p0);
    send_frame('{byte_t'(set_led), p0, 8'h00, 8'h00}, 2, rx);
    check_value("led_red", 32'(led_red), 32'(p0[0]));
    check_value("led_green", 32'(led_green), 32'(p0[1]));
    check_value("led_blue", 32'(led_blue), 32'(p0[2]));

    random_byte(p0);
    send_frame('{byte_t'(set_esp_status), p0, 8'h00, 8'h00}, 2, rx);
    check_value("esp_status", 32'(esp_status), 32'(p0));

    random_byte(p0);
    send_frame('{byte_t'(set_full_addr), p0, 8'h00, 8'h00}, 2, rx);
    check_value("full_addr", 32'(full_addr), 32'(|p0));
    send_frame('{byte_t'(set_full_addr), 8'h00, 8'h00, 8'h00}, 2, rx);
    check_value("full_addr", 32'(full_addr), 32'd0);

    random_byte(p0);
    random_byte(p1);
    random_byte(p2);
    send_frame('{byte_t'(set_screen_color), p0, p1, p2}, 4, rx);
    check_value("screen_color", 32'(screen_color),
                (32'(p0) << 16) | (32'(p1) << 8) | 32'(p2));

    // reply comes back in the dummy byte
    send_frame('{byte_t'(get_cookie), 8'h00, 8'h00, 8'h00}, 2, rx);
    check_value("miso byte", 32'(rx), 32'(`ESP_COOKIE));
    send_frame('{byte_t'(get_version), 8'h00, 8'h00, 8'h00}, 2, rx);
    check_value("miso byte", 32'(rx),
                32'(`ESP_VERSION_MAJOR) * 32 + 32'(`ESP_VERSION_MINOR));
    random_byte(p0);
    conf = p0[3:0];
    send_frame('{byte_t'(get_config), 8'h00, 8'h00, 8'h00}, 2, rx);
    check_value("miso byte", 32'(rx), 32'(p0[3:0]));

    // unknown opcode must not swallow the next byte
    random_byte(p0);
    p0[2:0] = ~{led_blue, led_green, led_red};
    send_frame('{8'h05, byte_t'(set_led), p0, 8'h00}, 3, rx);
    check_value("led_red", 32'(led_red), 32'(p0[0]));
    check_value("led_green", 32'(led_green), 32'(p0[1]));
    check_value("led_blue", 32'(led_blue), 32'(p0[2]));

    start_frame();
    shift_bits(byte_t'(set_led), 4, rx);  // cut short
    end_frame();
    p0 = ~esp_status;
    send_frame('{byte_t'(set_esp_status), p0, 8'h00, 8'h00}, 2, rx);
    check_value("esp_status", 32'(esp_status), 32'(p0));

    tick(5);
    if (dut0.props0.err_cnt == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1, "property failures");
    end
  end

endmodule

/* tb/esp_link_props.sv */
`timescale 1ns/1ps
`include "esp_link_settings.svh"

module esp_link_props (
  input logic                clk,
  input logic                rst,
  input logic                cs_n,
  input logic                miso,
  input logic                led_red,
  input logic                led_green,
  input logic                led_blue,
  input esp_link_pkg::byte_t esp_status,
  input logic                full_addr,
  input logic [23:0]         screen_color
);

  int unsigned err_cnt = 0;  // failures seen so far
  logic [3:0]  idle_cnt;     // cycles with cs_n high, saturating

  always_ff @(posedge clk) begin
    if (rst || !cs_n)
      idle_cnt <= '0;
    else if (idle_cnt != 4'hf)
      idle_cnt <= idle_cnt + 4'd1;
  end

  reset_values: assert property (@(posedge clk)
    rst |=> (!led_red && !led_green && !led_blue && esp_status == 8'h00 &&
             !full_addr && screen_color == `ESP_SCREEN_COLOR_RST))
    else begin
      $error("settings registers not at their reset values after reset");
      err_cnt++;
    end

  // no transfer in flight, so nothing may move
  hold_when_idle: assert property (@(posedge clk) disable iff (rst)
    (idle_cnt >= 4'd8) |=> $stable({led_red, led_green, led_blue, esp_status,
                                    full_addr, screen_color}))
    else begin
      $error("register outputs changed while cs_n stayed high");
      err_cnt++;
    end

  miso_low_idle: assert property (@(posedge clk) disable iff (rst)
    (idle_cnt >= 4'd3) |-> !miso)
    else begin
      $error("miso not low while cs_n is high");
      err_cnt++;
    end

endmodule

/* design/esp_link_top.sv */
`timescale 1ns/1ps

module esp_link_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                sck,
  input  logic                mosi,
  input  logic                cs_n,
  input  logic [3:0]          conf,
  output logic                miso,
  output logic                led_red,
  output logic                led_green,
  output logic                led_blue,
  output esp_link_pkg::byte_t esp_status,
  output logic                full_addr,
  output logic [23:0]         screen_color
);

  import esp_link_pkg::*;

  logic     rx_valid;
  byte_t    rx_byte;
  byte_t    tx_byte;
  logic     action;
  esp_cmd_e cmd;
  byte_t    param0;
  byte_t    param1;
  byte_t    param2;

  spi_target u_spi (
    .clk      (clk),
    .rst      (rst),
    .sck      (sck),
    .mosi     (mosi),
    .cs_n     (cs_n),
    .tx_byte  (tx_byte),
    .miso     (miso),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

  cmd_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .action   (action),
    .cmd      (cmd),
    .param0   (param0),
    .param1   (param1),
    .param2   (param2)
  );

  cmd_execute u_execute (
    .clk          (clk),
    .rst          (rst),
    .action       (action),
    .cmd          (cmd),
    .param0       (param0),
    .param1       (param1),
    .param2       (param2),
    .led_red      (led_red),
    .led_green    (led_green),
    .led_blue     (led_blue),
    .esp_status   (esp_status),
    .full_addr    (full_addr),
    .screen_color (screen_color)
  );

  // reply goes back out on the following transfer
  reply_select u_reply (
    .clk     (clk),
    .rst     (rst),
    .action  (action),
    .cmd     (cmd),
    .conf    (conf),
    .tx_byte (tx_byte)
  );

endmodule

/* design/reply_select.sv */
`timescale 1ns/1ps
`include "esp_link_settings.svh"

module reply_select (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   action,
  input  esp_link_pkg::esp_cmd_e cmd,
  input  logic [3:0]             conf,
  output esp_link_pkg::byte_t    tx_byte
);

  import esp_link_pkg::*;

  // reply for the next transfer, held until another get command
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_byte <= '0;
    end else if (action) begin
      case (cmd)
        get_cookie:  tx_byte <= `ESP_COOKIE;
        get_version: tx_byte <= {`ESP_VERSION_MAJOR, `ESP_VERSION_MINOR};
        get_config:  tx_byte <= {4'b0000, conf};  // board strap pins
        default:     tx_byte <= tx_byte;
      endcase
    end
  end

endmodule

/* design/cmd_execute.sv */
`timescale 1ns/1ps
`include "esp_link_settings.svh"

module cmd_execute (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   action,
  input  esp_link_pkg::esp_cmd_e cmd,
  input  esp_link_pkg::byte_t    param0,
  input  esp_link_pkg::byte_t    param1,
  input  esp_link_pkg::byte_t    param2,
  output logic                   led_red,
  output logic                   led_green,
  output logic                   led_blue,
  output esp_link_pkg::byte_t    esp_status,
  output logic                   full_addr,
  output logic [23:0]            screen_color
);

  import esp_link_pkg::*;

  // board settings, each written by its own set command
  always_ff @(posedge clk) begin
    if (rst) begin
      led_red      <= 1'b0;
      led_green    <= 1'b0;
      led_blue     <= 1'b0;
      esp_status   <= '0;
      full_addr    <= 1'b0;
      screen_color <= `ESP_SCREEN_COLOR_RST;
    end else if (action) begin
      case (cmd)
        set_led: begin
          led_red   <= param0[0];
          led_green <= param0[1];
          led_blue  <= param0[2];
        end
        set_esp_status: begin
          esp_status <= param0;  // ready, wifi, smb and sd flags
        end
        set_full_addr: begin
          full_addr <= (param0 != 8'h00);
        end
        set_screen_color: begin
          screen_color <= {param0, param1, param2};  // r, g, b
        end
        default: ;  // get commands leave settings alone
      endcase
    end
  end

endmodule

/* design/cmd_decode.sv */
`timescale 1ns/1ps
`include "esp_link_settings.svh"

module cmd_decode (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rx_valid,
  input  esp_link_pkg::byte_t    rx_byte,
  output logic                   action,
  output esp_link_pkg::esp_cmd_e cmd,
  output esp_link_pkg::byte_t    param0,
  output esp_link_pkg::byte_t    param1,
  output esp_link_pkg::byte_t    param2
);

  import esp_link_pkg::*;

  localparam int cnt_w = $clog2(`ESP_MAX_PARAMS + 1);

  decode_state_e    state;
  esp_cmd_e         opcode;   // incoming byte read as an opcode
  esp_cmd_e         op_q;     // command whose parameters are being collected
  logic [cnt_w-1:0] remain;   // parameter bytes still expected
  logic [cnt_w-1:0] idx;
  byte_t            pbuf [`ESP_MAX_PARAMS];
  byte_t            par_q [`ESP_MAX_PARAMS];
  logic             no_params;
  logic             last_param;
  logic             done;

  assign opcode     = esp_cmd_e'(rx_byte);
  assign no_params  = (opcode == get_cookie) || (opcode == get_version) ||
                      (opcode == get_config);
  assign last_param = (remain == cnt_w'(1));
  assign done       = rx_valid && ((state == st_idle) ? no_params : last_param);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      action <= 1'b0;
      remain <= '0;
      idx    <= '0;
    end else begin
      action <= done;
      if (rx_valid) begin
        case (state)
          st_idle: begin
            idx <= '0;
            case (opcode)
              set_screen_color: begin
                remain <= cnt_w'(3);
                state  <= st_read_params;
              end
              set_led, set_esp_status, set_full_addr: begin
                remain <= cnt_w'(1);
                state  <= st_read_params;
              end
              default: state <= st_idle;  // get commands fire at once, unknown ones drop
            endcase
          end
          default: begin
            idx    <= idx + cnt_w'(1);
            remain <= remain - cnt_w'(1);
            if (last_param) state <= st_idle;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) begin
      if (state == st_idle)
        op_q <= opcode;
      else
        pbuf[idx] <= rx_byte;
    end
  end

  // outputs only move together with action
  always_ff @(posedge clk) begin
    if (done) begin
      cmd <= (state == st_idle) ? opcode : op_q;
      for (int i = 0; i < `ESP_MAX_PARAMS; i++) begin
        par_q[i] <= (state == st_read_params && idx == cnt_w'(i)) ? rx_byte : pbuf[i];
      end
    end
  end

  assign param0 = par_q[0];
  assign param1 = par_q[1];
  assign param2 = par_q[2];

endmodule

/* design/spi_target.sv */
`timescale 1ns/1ps

module spi_target (
  input  logic                clk,
  input  logic                rst,
  input  logic                sck,
  input  logic                mosi,
  input  logic                cs_n,
  input  esp_link_pkg::byte_t tx_byte,
  output logic                miso,
  output logic                rx_valid,
  output esp_link_pkg::byte_t rx_byte
);

  import esp_link_pkg::*;

  logic [2:0] sck_r;   // two sync stages plus one for edge detect
  logic [1:0] cs_r;
  logic [1:0] mosi_r;
  logic [2:0] bit_cnt;
  byte_t      tx_sr;   // reply shifter, top bit is on miso
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_r  <= '0;
      cs_r   <= '1;  // link idle
      mosi_r <= '0;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[0], cs_n};
      mosi_r <= {mosi_r[0], mosi};
    end
  end

  assign sck_rise  = (sck_r[2:1] == 2'b01);
  assign sck_fall  = (sck_r[2:1] == 2'b10);
  assign cs_active = ~cs_r[1];

  // bit counter, mode 0 samples on rising sck
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;  // partial byte is dropped
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        rx_valid <= (bit_cnt == 3'd7);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) rx_byte <= {rx_byte[6:0], mosi_r[1]};  // msb first
  end

  // reply byte is loaded at every byte boundary
  always_ff @(posedge clk) begin
    if (!cs_active) begin
      tx_sr <= tx_byte;
    end else if (sck_fall) begin
      if (bit_cnt == 3'd0)
        tx_sr <= tx_byte;  // falling edge closing the previous byte
      else
        tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

  assign miso = cs_active ? tx_sr[7] : 1'b0;

endmodule

/* design/esp_link_pkg.sv */
package esp_link_pkg;

  typedef logic [7:0] byte_t;  // one byte on the link

  // opcode values as used by the co-processor firmware
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    set_full_addr    = 8'd14,
    get_version      = 8'd15,
    set_screen_color = 8'd17,
    set_led          = 8'd26,
    get_config       = 8'd27,
    set_esp_status   = 8'd32
  } esp_cmd_e;

  // command decoder FSM
  typedef enum logic {
    st_idle,
    st_read_params
  } decode_state_e;

endpackage

/* design/esp_link_settings.svh */
`ifndef ESP_LINK_SETTINGS_SVH
`define ESP_LINK_SETTINGS_SVH

// identification byte returned by get_cookie
`define ESP_COOKIE 8'haf

// version reply, major in the top 3 bits and minor in the low 5
`define ESP_VERSION_MAJOR 3'd0
`define ESP_VERSION_MINOR 5'd3

// longest parameter list of any supported command
`define ESP_MAX_PARAMS 3

// screen colour after reset is white
`define ESP_SCREEN_COLOR_RST 24'hffffff

`endif
